// File: mist_pkg.sv
/* shared definitions: SPI command opcodes, status bit positions,
   OSD window geometry and colour widening */
package mist_pkg;

   // control channel opcodes, select spi_ss_io
   typedef enum logic [7:0] {
      UIO_JOY0     = 8'h01,
      UIO_JOY1     = 8'h02,
      UIO_GET_CONF = 8'h14,
      UIO_STATUS   = 8'h1E
   } uio_cmd_e;

   // download channel opcodes, select spi_ss_data
   typedef enum logic [7:0] {
      DIO_FILE_TX   = 8'h53,
      DIO_FILE_DATA = 8'h54
   } dio_cmd_e;

   parameter int STATUS_OSD_BIT        = 0;
   parameter int STATUS_YPBPR_BIT      = 1;
   parameter int STATUS_SCAN2X_DIS_BIT = 2;

   // OSD window, in active pixels and lines
   parameter int OSD_X0 = 16;
   parameter int OSD_Y0 = 8;
   parameter int OSD_W  = 32;
   parameter int OSD_H  = 16;

   // widen a w-bit colour to 6 bits, colour sits in the low bits of a
   function automatic logic [5:0] extend_color(input logic [7:0] a, input int w);
      logic [5:0] c;
      case (w)
         3: c = {a[2:0], a[2:0]};
         4: c = {a[3:0], a[3:2]};
         5: c = {a[4:0], a[4]};
         7: c = a[6:1];          // wider inputs lose their low bits
         8: c = a[7:2];
         default: c = a[5:0];
      endcase
      return c;
   endfunction

endpackage

// File: video_if.sv
/* video bus between OSD overlay and output encoder */
`timescale 1ns/1ps

interface video_if;
   logic [5:0] r;
   logic [5:0] g;
   logic [5:0] b;
   logic       hs;
   logic       vs;

   // overlay drives, encoder reads
   modport source (
      output r, g, b, hs, vs
   );

   modport sink (
      input r, g, b, hs, vs
   );
endinterface

// File: spi_user_io.sv
/* SPI control slave: command decode, status and joystick registers,
   configuration string readback on MISO */
`timescale 1ns/1ps

module spi_user_io import mist_pkg::*; #(
   parameter int                        CONF_STR_LEN = 4,
   parameter logic [CONF_STR_LEN*8-1:0] CONF_STR     = "CORE"
) (
   input  logic        clk_sys,
   input  logic        reset_i,
   input  logic        spi_sck_i,
   input  logic        spi_mosi_i,
   input  logic        spi_ss_io_i,
   output logic        spi_miso_o,
   output logic [31:0] status_o,
   output logic [31:0] joystick1_o,
   output logic [31:0] joystick2_o
);

   typedef enum logic [1:0] {ST_CMD, ST_DATA, ST_DONE} uio_state_e;

   uio_state_e  state;
   uio_cmd_e    cmd;
   logic [2:0]  sck_sr;
   logic [1:0]  mosi_sr;
   logic [1:0]  ss_sr;
   logic        sck_rise;
   logic        sck_fall;
   logic [2:0]  bit_cnt;
   logic [6:0]  sreg;
   logic [7:0]  rx_byte;
   logic [1:0]  stat_idx;
   logic [23:0] stat_sh;     // low status bytes until the fourth arrives
   logic [15:0] char_idx;
   logic [7:0]  tx_byte;

   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         sck_sr <= '0;
         ss_sr  <= 2'b11;  // deselected
      end else begin
         sck_sr <= {sck_sr[1:0], spi_sck_i};
         ss_sr  <= {ss_sr[0], spi_ss_io_i};
      end
      mosi_sr <= {mosi_sr[0], spi_mosi_i};
   end

   assign sck_rise = sck_sr[1] & ~sck_sr[2];
   assign sck_fall = ~sck_sr[1] & sck_sr[2];
   assign rx_byte  = {sreg, mosi_sr[1]};

   // string goes out first character first, zeros past the end
   always_comb begin
      if (char_idx < CONF_STR_LEN)
         tx_byte = CONF_STR[(CONF_STR_LEN - 1 - char_idx) * 8 +: 8];
      else
         tx_byte = 8'h00;
   end

   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         state       <= ST_CMD;
         bit_cnt     <= '0;
         stat_idx    <= '0;
         char_idx    <= '0;
         status_o    <= '0;
         joystick1_o <= '0;
         joystick2_o <= '0;
         spi_miso_o  <= 1'b0;
      end else if (ss_sr[1]) begin  // select high drops any partial byte
         state      <= ST_CMD;
         bit_cnt    <= '0;
         stat_idx   <= '0;
         char_idx   <= '0;
         spi_miso_o <= 1'b0;
      end else begin
         if (sck_rise) begin
            sreg    <= rx_byte[6:0];
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
               case (state)
                  ST_CMD: begin
                     cmd   <= uio_cmd_e'(rx_byte);
                     state <= ST_DATA;
                  end
                  ST_DATA: begin
                     case (cmd)
                        UIO_JOY0: begin
                           joystick1_o <= {24'd0, rx_byte};
                           state       <= ST_DONE;
                        end
                        UIO_JOY1: begin
                           joystick2_o <= {24'd0, rx_byte};
                           state       <= ST_DONE;
                        end
                        UIO_STATUS: begin
                           stat_idx <= stat_idx + 2'd1;
                           if (stat_idx == 2'd3) begin
                              status_o <= {rx_byte, stat_sh};
                              state    <= ST_DONE;
                           end else begin
                              stat_sh <= {rx_byte, stat_sh[23:8]};  // lsb first
                           end
                        end
                        UIO_GET_CONF: begin
                           if (char_idx < CONF_STR_LEN)
                              char_idx <= char_idx + 16'd1;
                        end
                        default: state <= ST_DONE;  // unknown opcode
                     endcase
                  end
                  default: ;
               endcase
            end
         end
         if (sck_fall) begin
            if (state == ST_DATA && cmd == UIO_GET_CONF)
               spi_miso_o <= tx_byte[3'd7 - bit_cnt];  // msb first
            else
               spi_miso_o <= 1'b0;
         end
      end
   end

endmodule

// File: spi_data_io.sv
/* SPI download slave: file transfer commands, ROM address counter,
   byte write strobe */
`timescale 1ns/1ps

module spi_data_io import mist_pkg::*; (
   input  logic        clk_sys,
   input  logic        reset_i,
   input  logic        spi_sck_i,
   input  logic        spi_mosi_i,
   input  logic        spi_ss_data_i,
   output logic [22:0] ioctl_addr_o,
   output logic [7:0]  ioctl_data_o,
   output logic        ioctl_wr_o,
   output logic        downloading_o
);

   typedef enum logic [1:0] {ST_CMD, ST_TX, ST_DATA, ST_DONE} dio_state_e;

   dio_state_e state;
   logic [2:0] sck_sr;
   logic [1:0] mosi_sr;
   logic [1:0] ss_sr;
   logic [2:0] bit_cnt;
   logic [6:0] sreg;
   logic [7:0] rx_byte;
   logic       byte_done;

   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         sck_sr <= '0;
         ss_sr  <= 2'b11;
      end else begin
         sck_sr <= {sck_sr[1:0], spi_sck_i};
         ss_sr  <= {ss_sr[0], spi_ss_data_i};
      end
      mosi_sr <= {mosi_sr[0], spi_mosi_i};
   end

   assign rx_byte   = {sreg, mosi_sr[1]};
   assign byte_done = ~ss_sr[1] & sck_sr[1] & ~sck_sr[2] & (bit_cnt == 3'd7);

   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         state         <= ST_CMD;
         bit_cnt       <= '0;
         ioctl_addr_o  <= '0;
         ioctl_wr_o    <= 1'b0;
         downloading_o <= 1'b0;
      end else begin
         ioctl_wr_o <= 1'b0;
         if (ioctl_wr_o)
            ioctl_addr_o <= ioctl_addr_o + 23'd1;  // next byte goes one up
         if (ss_sr[1]) begin
            state   <= ST_CMD;
            bit_cnt <= '0;
         end else if (sck_sr[1] & ~sck_sr[2]) begin
            sreg    <= rx_byte[6:0];
            bit_cnt <= bit_cnt + 3'd1;
         end
         if (byte_done) begin
            case (state)
               ST_CMD: begin
                  if (rx_byte == DIO_FILE_TX)
                     state <= ST_TX;
                  else if (rx_byte == DIO_FILE_DATA)
                     state <= ST_DATA;
                  else
                     state <= ST_DONE;
               end
               ST_TX: begin
                  downloading_o <= |rx_byte;  // zero ends the transfer
                  if (|rx_byte)
                     ioctl_addr_o <= '0;
                  state <= ST_DONE;
               end
               ST_DATA: ioctl_wr_o <= downloading_o;
               default: ;
            endcase
         end
      end
   end

   // data byte lines up with the write pulse
   always_ff @(posedge clk_sys) begin
      if (byte_done && state == ST_DATA)
         ioctl_data_o <= rx_byte;
   end

endmodule

// File: osd_overlay.sv
/* colour widening, active pixel and line counters,
   OSD window tint with one register stage */
`timescale 1ns/1ps

module osd_overlay import mist_pkg::*; #(
   parameter int COLORW = 4
) (
   input  logic              clk_sys,
   input  logic              reset_i,
   input  logic [COLORW-1:0] game_r_i,
   input  logic [COLORW-1:0] game_g_i,
   input  logic [COLORW-1:0] game_b_i,
   input  logic              lhbl_i,
   input  logic              lvbl_i,
   input  logic              hs_i,
   input  logic              vs_i,
   input  logic              pxl_cen_i,
   input  logic [31:0]       status_i,
   output logic              osd_shown_o,
   video_if.source           vid_o
);

   logic [9:0] hcnt;    // active pixel inside the line
   logic [8:0] vcnt;    // active line inside the frame
   logic       lhbl_q;
   logic       in_win;
   logic       tint;
   logic [5:0] r6;
   logic [5:0] g6;
   logic [5:0] b6;

   assign r6 = extend_color(8'(game_r_i), COLORW);
   assign g6 = extend_color(8'(game_g_i), COLORW);
   assign b6 = extend_color(8'(game_b_i), COLORW);

   // pxl_cen_i closes the current pixel, both counters clear in blanking
   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         hcnt   <= '0;
         vcnt   <= '0;
         lhbl_q <= 1'b0;
      end else begin
         lhbl_q <= lhbl_i;
         if (!lhbl_i)
            hcnt <= '0;
         else if (pxl_cen_i)
            hcnt <= hcnt + 10'd1;
         if (!lvbl_i)
            vcnt <= '0;
         else if (lhbl_q && !lhbl_i)
            vcnt <= vcnt + 9'd1;  // end of an active line
      end
   end

   assign in_win = (hcnt >= OSD_X0) && (hcnt < OSD_X0 + OSD_W) &&
                   (vcnt >= OSD_Y0) && (vcnt < OSD_Y0 + OSD_H);
   assign tint        = in_win & status_i[STATUS_OSD_BIT];
   assign osd_shown_o = status_i[STATUS_OSD_BIT];

   always_ff @(posedge clk_sys) begin
      vid_o.r  <= tint ? {1'b0, r6[5:1]} : r6;  // dimmed under the OSD
      vid_o.g  <= tint ? {1'b0, g6[5:1]} : g6;
      vid_o.b  <= tint ? {1'b1, b6[5:1]} : b6;  // blue cast
      vid_o.hs <= hs_i;
      vid_o.vs <= vs_i;
   end

endmodule

// File: video_encoder.sv
/* RGB to YPbPr conversion, composite sync selection,
   registered video outputs */
`timescale 1ns/1ps

module video_encoder import mist_pkg::*; (
   input  logic        clk_sys,
   input  logic        reset_i,
   input  logic [31:0] status_i,
   video_if.sink       vid_i,
   output logic [5:0]  video_r_o,
   output logic [5:0]  video_g_o,
   output logic [5:0]  video_b_o,
   output logic        video_hs_o,
   output logic        video_vs_o
);

   logic              ypbpr;
   logic [8:0]        y_sum;
   logic [5:0]        y6;
   logic signed [9:0] pb_s;
   logic signed [9:0] pr_s;

   function automatic logic [5:0] clip6(input logic signed [9:0] v);
      logic [5:0] c;
      if (v < 0)
         c = 6'd0;
      else if (v > 63)
         c = 6'd63;
      else
         c = v[5:0];
      return c;
   endfunction

   assign ypbpr = status_i[STATUS_YPBPR_BIT];
   assign y_sum = 9'(vid_i.r) * 9'd2 + 9'(vid_i.g) * 9'd5 + 9'(vid_i.b);
   assign y6    = y_sum[8:3];   // divide by 8
   assign pb_s  = 10'sd32 + $signed({5'd0, vid_i.b[5:1]}) - $signed({4'd0, y6});
   assign pr_s  = 10'sd32 + $signed({5'd0, vid_i.r[5:1]}) - $signed({4'd0, y6});

   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         video_r_o  <= '0;
         video_g_o  <= '0;
         video_b_o  <= '0;
         video_hs_o <= 1'b0;
         video_vs_o <= 1'b0;
      end else if (ypbpr) begin
         video_r_o  <= clip6(pr_s);  // channel order R=Pr G=Y B=Pb
         video_g_o  <= y6;
         video_b_o  <= clip6(pb_s);
         video_hs_o <= ~(vid_i.hs ^ vid_i.vs);  // composite sync
         video_vs_o <= 1'b1;
      end else begin
         video_r_o  <= vid_i.r;
         video_g_o  <= vid_i.g;
         video_b_o  <= vid_i.b;
         video_hs_o <= vid_i.hs;
         video_vs_o <= vid_i.vs;
      end
   end

endmodule

// File: sigma_delta_dac.sv
/* first order sigma-delta audio DAC with 1-bit output */
`timescale 1ns/1ps

module sigma_delta_dac #(
   parameter bit SIGNED_SND = 1'b0
) (
   input  logic        clk_sys,
   input  logic        reset_i,
   input  logic [15:0] pcm_i,
   output logic        dac_o
);

   logic [15:0] pcm_u;
   logic [15:0] acc;

   // offset binary for signed samples
   assign pcm_u = {pcm_i[15] ^ SIGNED_SND, pcm_i[14:0]};

   // overflow of the accumulator is the output bit
   // so ones density comes out as pcm_u / 65536
   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         acc   <= '0;
         dac_o <= 1'b0;
      end else begin
         {dac_o, acc} <= {1'b0, acc} + {1'b0, pcm_u};
      end
   end

endmodule

// File: mist_base.sv
/* platform base top: SPI control and download slaves, OSD overlay,
   video encoder, stereo audio DACs */
`timescale 1ns/1ps

module mist_base import mist_pkg::*; #(
   parameter int                        CONF_STR_LEN = 4,
   parameter logic [CONF_STR_LEN*8-1:0] CONF_STR     = "CORE",
   parameter bit                        SIGNED_SND   = 1'b0,
   parameter int                        COLORW       = 4
) (
   input  logic              clk_sys,
   input  logic              reset_i,
   // SPI from the I/O controller
   input  logic              spi_sck_i,
   input  logic              spi_mosi_i,
   input  logic              spi_ss_io_i,
   input  logic              spi_ss_data_i,
   output logic              spi_miso_o,   // tri-stated off chip
   output logic [31:0]       status_o,
   output logic [31:0]       joystick1_o,
   output logic [31:0]       joystick2_o,
   output logic              scan2x_enb_o,
   // ROM download
   output logic [22:0]       ioctl_addr_o,
   output logic [7:0]        ioctl_data_o,
   output logic              ioctl_wr_o,
   output logic              downloading_o,
   // game video
   input  logic [COLORW-1:0] game_r_i,
   input  logic [COLORW-1:0] game_g_i,
   input  logic [COLORW-1:0] game_b_i,
   input  logic              lhbl_i,
   input  logic              lvbl_i,
   input  logic              hs_i,
   input  logic              vs_i,
   input  logic              pxl_cen_i,
   output logic              osd_shown_o,
   output logic [5:0]        video_r_o,
   output logic [5:0]        video_g_o,
   output logic [5:0]        video_b_o,
   output logic              video_hs_o,
   output logic              video_vs_o,
   // sound
   input  logic [15:0]       snd_left_i,
   input  logic [15:0]       snd_right_i,
   output logic              snd_pwm_left_o,
   output logic              snd_pwm_right_o
);

   video_if vid ();

   assign scan2x_enb_o = status_o[STATUS_SCAN2X_DIS_BIT];

   spi_user_io #(
      .CONF_STR_LEN (CONF_STR_LEN),
      .CONF_STR     (CONF_STR)
   ) u_user_io (
      .clk_sys     (clk_sys),
      .reset_i     (reset_i),
      .spi_sck_i   (spi_sck_i),
      .spi_mosi_i  (spi_mosi_i),
      .spi_ss_io_i (spi_ss_io_i),
      .spi_miso_o  (spi_miso_o),
      .status_o    (status_o),
      .joystick1_o (joystick1_o),
      .joystick2_o (joystick2_o)
   );

   spi_data_io u_data_io (
      .clk_sys       (clk_sys),
      .reset_i       (reset_i),
      .spi_sck_i     (spi_sck_i),
      .spi_mosi_i    (spi_mosi_i),
      .spi_ss_data_i (spi_ss_data_i),
      .ioctl_addr_o  (ioctl_addr_o),
      .ioctl_data_o  (ioctl_data_o),
      .ioctl_wr_o    (ioctl_wr_o),
      .downloading_o (downloading_o)
   );

   osd_overlay #(.COLORW(COLORW)) u_osd (
      .clk_sys     (clk_sys),
      .reset_i     (reset_i),
      .game_r_i    (game_r_i),
      .game_g_i    (game_g_i),
      .game_b_i    (game_b_i),
      .lhbl_i      (lhbl_i),
      .lvbl_i      (lvbl_i),
      .hs_i        (hs_i),
      .vs_i        (vs_i),
      .pxl_cen_i   (pxl_cen_i),
      .status_i    (status_o),
      .osd_shown_o (osd_shown_o),
      .vid_o       (vid.source)
   );

   video_encoder u_encoder (
      .clk_sys    (clk_sys),
      .reset_i    (reset_i),
      .status_i   (status_o),
      .vid_i      (vid.sink),
      .video_r_o  (video_r_o),
      .video_g_o  (video_g_o),
      .video_b_o  (video_b_o),
      .video_hs_o (video_hs_o),
      .video_vs_o (video_vs_o)
   );

   sigma_delta_dac #(.SIGNED_SND(SIGNED_SND)) u_dac_left (
      .clk_sys (clk_sys),
      .reset_i (reset_i),
      .pcm_i   (snd_left_i),
      .dac_o   (snd_pwm_left_o)
   );

   sigma_delta_dac #(.SIGNED_SND(SIGNED_SND)) u_dac_right (
      .clk_sys (clk_sys),
      .reset_i (reset_i),
      .pcm_i   (snd_right_i),
      .dac_o   (snd_pwm_right_o)
   );

endmodule

// File: mist_base_chk.sv
/* bound checker for mist_base: two-cycle video path with OSD tint and
   YPbPr encoding, download write strobe and address rules */
`timescale 1ns/1ps

module mist_base_chk import mist_pkg::*; (
   input logic        clk_sys,
   input logic        reset_i,
   input logic [3:0]  game_r_i,
   input logic [3:0]  game_g_i,
   input logic [3:0]  game_b_i,
   input logic        lhbl_i,
   input logic        lvbl_i,
   input logic        hs_i,
   input logic        vs_i,
   input logic        pxl_cen_i,
   input logic [31:0] status_i,
   input logic [5:0]  video_r_i,
   input logic [5:0]  video_g_i,
   input logic [5:0]  video_b_i,
   input logic        video_hs_i,
   input logic        video_vs_i,
   input logic        ioctl_wr_i,
   input logic [22:0] ioctl_addr_i,
   input logic        downloading_i
);

   int         fail_cnt = 0;  // read by the testbench
   logic [9:0] px;            // active pixel, own count
   logic [8:0] ln;            // active line, own count
   logic       lhbl_d;
   logic       in_win;

   // 4-bit colour to 6 bits, then the window tint, syncs ride along
   function automatic logic [19:0] shade(input logic [13:0] raw, input logic t);
      logic [5:0] r;
      logic [5:0] g;
      logic [5:0] b;
      r = {raw[13:10], raw[13:12]};
      g = {raw[9:6], raw[9:8]};
      b = {raw[5:2], raw[5:4]};
      if (t) begin
         r = r / 2;
         g = g / 2;
         b = b / 2 + 6'd32;
      end
      return {r, g, b, raw[1:0]};
   endfunction

   // output channel order R=Pr G=Y B=Pb, csync on hs
   function automatic logic [19:0] encode(input logic [19:0] p, input logic yp);
      int r, g, b, y, pb, pr;
      r = p[19:14];
      g = p[13:8];
      b = p[7:2];
      if (!yp)
         return p;
      y  = (2 * r + 5 * g + b) / 8;
      pb = 32 + b / 2 - y;
      pr = 32 + r / 2 - y;
      pb = (pb < 0) ? 0 : ((pb > 63) ? 63 : pb);
      pr = (pr < 0) ? 0 : ((pr > 63) ? 63 : pr);
      return {6'(pr), 6'(y), 6'(pb), ~(p[1] ^ p[0]), 1'b1};
   endfunction

   always_ff @(posedge clk_sys) begin
      if (reset_i) begin
         px     <= '0;
         ln     <= '0;
         lhbl_d <= 1'b0;
      end else begin
         lhbl_d <= lhbl_i;
         if (!lhbl_i)
            px <= '0;
         else if (pxl_cen_i)
            px <= px + 10'd1;
         if (!lvbl_i)
            ln <= '0;
         else if (lhbl_d && !lhbl_i)
            ln <= ln + 9'd1;
      end
   end

   assign in_win = (px >= OSD_X0) && (px < OSD_X0 + OSD_W) &&
                   (ln >= OSD_Y0) && (ln < OSD_Y0 + OSD_H);

   a_video: assert property (@(posedge clk_sys)
      (!$past(reset_i) && !$past(reset_i, 2)) |->
         {video_r_i, video_g_i, video_b_i, video_hs_i, video_vs_i} ==
            encode(shade($past({game_r_i, game_g_i, game_b_i, hs_i, vs_i}, 2),
                         $past(in_win && status_i[STATUS_OSD_BIT], 2)),
                   $past(status_i[STATUS_YPBPR_BIT])))
   else begin
      fail_cnt++;
      $error("video outputs differ from the two-cycle overlay and encoder model");
   end

   a_wr_pulse: assert property (@(posedge clk_sys) disable iff (reset_i)
      ioctl_wr_i |-> downloading_i ##1 !ioctl_wr_i)
   else begin
      fail_cnt++;
      $error("write strobe longer than one cycle or outside a download");
   end

   a_addr_step: assert property (@(posedge clk_sys) disable iff (reset_i)
      ioctl_wr_i |=> ioctl_addr_i == $past(ioctl_addr_i) + 23'd1)
   else begin
      fail_cnt++;
      $error("download address did not step by one after a write");
   end

endmodule

bind mist_base mist_base_chk u_chk (
   .clk_sys       (clk_sys),
   .reset_i       (reset_i),
   .game_r_i      (game_r_i),
   .game_g_i      (game_g_i),
   .game_b_i      (game_b_i),
   .lhbl_i        (lhbl_i),
   .lvbl_i        (lvbl_i),
   .hs_i          (hs_i),
   .vs_i          (vs_i),
   .pxl_cen_i     (pxl_cen_i),
   .status_i      (status_o),
   .video_r_i     (video_r_o),
   .video_g_i     (video_g_o),
   .video_b_i     (video_b_o),
   .video_hs_i    (video_hs_o),
   .video_vs_i    (video_vs_o),
   .ioctl_wr_i    (ioctl_wr_o),
   .ioctl_addr_i  (ioctl_addr_o),
   .downloading_i (downloading_o)
);

// File: tb_mist_base.sv
/* testbench for mist_base: SPI control and download traffic,
   video frames through the bound checker, audio DAC density */
`timescale 1ns/1ps

module tb_mist_base import mist_pkg::*; ;

   localparam int COLORW      = 4;
   localparam int SPI_HALF    = 4;    // clocks per sck phase
   localparam int DL_LEN      = 20;
   localparam int LINE_CYC    = 144;  // 128 active plus 16 blanking
   localparam int FRAME_LINES = 36;
   localparam int XFER_CYC    = 16 * SPI_HALF + 2;
   localparam int TEST_CYC    = 10 + 90 * XFER_CYC + 4 * FRAME_LINES * LINE_CYC + 4100;
   localparam int MAX_CYC     = TEST_CYC * 3 / 2;

   logic              clk_sys = 1'b0;
   logic              reset_i;
   logic              spi_sck_i;
   logic              spi_mosi_i;
   logic              spi_ss_io_i;
   logic              spi_ss_data_i;
   logic              spi_miso_o;
   logic [31:0]       status_o;
   logic [31:0]       joystick1_o;
   logic [31:0]       joystick2_o;
   logic              scan2x_enb_o;
   logic [22:0]       ioctl_addr_o;
   logic [7:0]        ioctl_data_o;
   logic              ioctl_wr_o;
   logic              downloading_o;
   logic [COLORW-1:0] game_r_i;
   logic [COLORW-1:0] game_g_i;
   logic [COLORW-1:0] game_b_i;
   logic              lhbl_i;
   logic              lvbl_i;
   logic              hs_i;
   logic              vs_i;
   logic              pxl_cen_i;
   logic              osd_shown_o;
   logic [5:0]        video_r_o;
   logic [5:0]        video_g_o;
   logic [5:0]        video_b_o;
   logic              video_hs_o;
   logic              video_vs_o;
   logic [15:0]       snd_left_i;
   logic [15:0]       snd_right_i;
   logic              snd_pwm_left_o;
   logic              snd_pwm_right_o;

   logic [31:0] lcg_state = 32'h52de;
   logic [7:0]  dl_data [DL_LEN];
   string       conf_txt = "JTCORE;;";
   int          errors = 0;
   int          tests_ok = 0;
   int          tests_bad = 0;
   int          cycles = 0;
   int          wr_seen = 0;

   mist_base #(
      .CONF_STR_LEN (8),
      .CONF_STR     ("JTCORE;;"),
      .SIGNED_SND   (1'b1),
      .COLORW       (COLORW)
   ) dut (.*);

   always #20 clk_sys = ~clk_sys;

   always @(posedge clk_sys) begin
      cycles++;
      if (cycles > MAX_CYC) begin
         $display("timeout: run stopped after %0d cycles", cycles);
         $display("TEST FAILED");
         $finish;
      end
   end

   // each write strobe against the bytes sent
   always @(negedge clk_sys) begin
      if (ioctl_wr_o) begin
         if (wr_seen < DL_LEN) begin
            check_val("ioctl_addr_o", wr_seen, ioctl_addr_o);
            check_val("ioctl_data_o", dl_data[wr_seen], ioctl_data_o);
         end
         wr_seen++;
      end
   end

   function automatic logic [7:0] rand_byte();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[23:16];
   endfunction

   function automatic int err_count();
      return errors + dut.u_chk.fail_cnt;
   endfunction

   task automatic tick(input int n);
      repeat (n) @(posedge clk_sys);
      #2;
   endtask

   task automatic check_val(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
      assert (act === exp)
      else begin
         errors++;
         $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic approx_check(input string name, input int exp, input int act);
      assert (act >= exp - 1 && act <= exp + 1)
      else begin
         errors++;
         $display("mismatch at %0t: %s expected %0d +-1 got %0d", $time, name, exp, act);
      end
   endtask

   task automatic finish_test(input string name, input int err_before);
      int now_err;
      now_err = err_count();
      if (now_err == err_before) begin
         tests_ok++;
         $display("test %s passed", name);
      end else begin
         tests_bad++;
         $display("test %s failed with %0d errors", name, now_err - err_before);
      end
   endtask

   // sck idles low, sample on rise, msb first
   task automatic xfer_byte(input logic [7:0] tx, output logic [7:0] rx);
      int i;
      for (i = 7; i >= 0; i--) begin
         spi_mosi_i = tx[i];
         tick(SPI_HALF);
         rx[i]     = spi_miso_o;  // set on the previous fall
         spi_sck_i = 1'b1;
         tick(SPI_HALF);
         spi_sck_i = 1'b0;
      end
   endtask

   task automatic open_link(input bit data_ch);
      if (data_ch)
         spi_ss_data_i = 1'b0;
      else
         spi_ss_io_i = 1'b0;
      tick(SPI_HALF);
   endtask

   task automatic close_link();
      tick(SPI_HALF);
      spi_ss_io_i   = 1'b1;
      spi_ss_data_i = 1'b1;
      tick(SPI_HALF);
   endtask

   task automatic write_status(input logic [31:0] w);
      logic [7:0] rx;
      int         i;
      open_link(1'b0);
      xfer_byte(UIO_STATUS, rx);
      for (i = 0; i < 4; i++)
         xfer_byte(w[8*i +: 8], rx);  // low byte first
      close_link();
   endtask

   // 64x32 active frame, pixel enable every second clock
   task automatic run_frame();
      logic [7:0] c;
      int         ln;
      int         px;
      for (ln = 0; ln < FRAME_LINES; ln++) begin
         lvbl_i = (ln >= 2 && ln < FRAME_LINES - 2);
         vs_i   = (ln != 0);
         lhbl_i = 1'b1;
         for (px = 0; px < 128; px++) begin
            pxl_cen_i = px[0];
            if (!px[0]) begin
               c        = rand_byte();
               game_r_i = c[3:0];
               game_g_i = c[7:4];
               c        = rand_byte();
               game_b_i = c[3:0];
            end
            tick(1);
         end
         lhbl_i    = 1'b0;
         pxl_cen_i = 1'b0;
         for (px = 0; px < 16; px++) begin
            hs_i = !(px >= 4 && px < 12);  // active low hsync
            tick(1);
         end
      end
   endtask

   initial begin
      logic [7:0]  rx;
      logic [7:0]  j1;
      logic [7:0]  j2;
      logic [31:0] word;
      int          e0;
      int          i;
      int          ones_l;
      int          ones_r;

      reset_i       = 1'b1;
      spi_sck_i     = 1'b0;
      spi_mosi_i    = 1'b0;
      spi_ss_io_i   = 1'b1;
      spi_ss_data_i = 1'b1;
      game_r_i      = '0;
      game_g_i      = '0;
      game_b_i      = '0;
      lhbl_i        = 1'b0;
      lvbl_i        = 1'b0;
      hs_i          = 1'b1;
      vs_i          = 1'b1;
      pxl_cen_i     = 1'b0;
      snd_left_i    = 16'h0000;
      snd_right_i   = 16'h4000;

      tick(9);
      e0 = err_count();
      check_val("status_o", 0, status_o);
      check_val("joystick1_o", 0, joystick1_o);
      check_val("joystick2_o", 0, joystick2_o);
      check_val("ioctl_wr_o", 0, ioctl_wr_o);
      check_val("downloading_o", 0, downloading_o);
      check_val("scan2x_enb_o", 0, scan2x_enb_o);
      check_val("osd_shown_o", 0, osd_shown_o);
      check_val("spi_miso_o", 0, spi_miso_o);
      check_val("snd_pwm_left_o", 0, snd_pwm_left_o);
      check_val("snd_pwm_right_o", 0, snd_pwm_right_o);
      tick(1);
      reset_i = 1'b0;
      finish_test("reset", e0);
      tick(4);

      e0   = err_count();
      word = {rand_byte(), rand_byte(), rand_byte(), rand_byte()};
      for (i = 0; i < 2; i++) begin
         write_status(word);
         check_val("status_o", word, status_o);
         check_val("scan2x_enb_o", word[STATUS_SCAN2X_DIS_BIT], scan2x_enb_o);
         check_val("osd_shown_o", word[STATUS_OSD_BIT], osd_shown_o);
         word = ~word;  // every bit seen at both levels
      end
      finish_test("status", e0);

      e0 = err_count();
      j1 = rand_byte();
      j2 = rand_byte();
      open_link(1'b0);
      xfer_byte(UIO_JOY0, rx);
      xfer_byte(j1, rx);
      close_link();
      open_link(1'b0);
      xfer_byte(UIO_JOY1, rx);
      xfer_byte(j2, rx);
      close_link();
      check_val("joystick1_o", {24'd0, j1}, joystick1_o);
      check_val("joystick2_o", {24'd0, j2}, joystick2_o);
      finish_test("joystick", e0);

      e0 = err_count();
      open_link(1'b0);
      xfer_byte(UIO_GET_CONF, rx);
      for (i = 0; i < 10; i++) begin
         xfer_byte(8'h00, rx);
         if (i < conf_txt.len())
            check_val("spi_miso_o byte", conf_txt[i], rx);
         else
            check_val("spi_miso_o byte", 8'h00, rx);  // past the end of the string
      end
      close_link();
      finish_test("config string", e0);

      e0 = err_count();
      for (i = 0; i < DL_LEN; i++)
         dl_data[i] = rand_byte();
      check_val("downloading_o", 0, downloading_o);
      open_link(1'b1);
      xfer_byte(DIO_FILE_TX, rx);
      xfer_byte(8'h01, rx);
      close_link();
      check_val("downloading_o", 1, downloading_o);
      wr_seen = 0;
      open_link(1'b1);
      xfer_byte(DIO_FILE_DATA, rx);
      for (i = 0; i < DL_LEN; i++)
         xfer_byte(dl_data[i], rx);
      close_link();
      check_val("downloading_o", 1, downloading_o);
      open_link(1'b1);
      xfer_byte(DIO_FILE_TX, rx);
      xfer_byte(8'h00, rx);
      close_link();
      check_val("downloading_o", 0, downloading_o);
      // data bytes after the end write nothing
      open_link(1'b1);
      xfer_byte(DIO_FILE_DATA, rx);
      xfer_byte(rand_byte(), rx);
      xfer_byte(rand_byte(), rx);
      close_link();
      check_val("write strobe count", DL_LEN, wr_seen);
      finish_test("download", e0);

      // one frame for each osd and ypbpr setting
      e0 = err_count();
      for (i = 0; i < 4; i++) begin
         write_status(32'(i));
         run_frame();
      end
      tick(4);
      finish_test("video", e0);

      // offset binary 0x8000 and 0xc000 over 4096 clocks
      e0     = err_count();
      ones_l = 0;
      ones_r = 0;
      for (i = 0; i < 4096; i++) begin
         tick(1);
         ones_l += snd_pwm_left_o;
         ones_r += snd_pwm_right_o;
      end
      approx_check("snd_pwm_left_o ones", 2048, ones_l);
      approx_check("snd_pwm_right_o ones", 3072, ones_r);
      finish_test("audio dac", e0);

      $display("tests passed %0d failed %0d total %0d",
               tests_ok, tests_bad, tests_ok + tests_bad);
      if (tests_bad == 0 && err_count() == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// File: compile.f
mist_pkg.sv
video_if.sv
spi_user_io.sv
spi_data_io.sv
osd_overlay.sv
video_encoder.sv
sigma_delta_dac.sv
mist_base.sv
mist_base_chk.sv
tb_mist_base.sv

// File: Bender.yml
package:
  name: mist_base

sources:
  - mist_pkg.sv
  - video_if.sv
  - spi_user_io.sv
  - spi_data_io.sv
  - osd_overlay.sv
  - video_encoder.sv
  - sigma_delta_dac.sv
  - mist_base.sv
  - target: test
    files:
      - mist_base_chk.sv
      - tb_mist_base.sv
